// ==== build.f ====
+incdir+tests
design/core_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/reg_file_scoreboard.sv
design/execute_stage.sv
design/npc_core.sv
tests/tb_core.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f build.f --top-module tb_core -o tb_core \
	&& ./obj_dir/tb_core > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "compile or run error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

// ==== tests/tb_ref_model.svh ====
// reference model for the rv64 subset; programs start at reset_pc and run at most 1000 steps
`ifndef tb_ref_model_svh
`define tb_ref_model_svh

// program image, written by the builders, loaded whole into imem
logic [inst_w-1:0] prog_mem [imem_depth];
int prog_len;
// expected retire stream, one entry per instruction in program order
logic [xlen-1:0] exp_pc [$];
logic [reg_addr_w-1:0] exp_rd [$];
logic [xlen-1:0] exp_data [$];
// random source for the random test
logic [31:0] lfsr_state = 32'hfcdb08b9;

// *********************************************************************
// instruction-set model
// *********************************************************************
function automatic void ref_run();
	logic [xlen-1:0] regs [reg_count];
	logic [xlen-1:0] pc, next_pc, res, a, b;
	logic [xlen-1:0] imm_i, imm_u, imm_j, imm_b;
	logic [inst_w-1:0] w;
	logic [6:0] opc, f7;
	logic [2:0] f3;
	logic [reg_addr_w-1:0] rd;
	logic wr, stop;
	int steps;
	regs = '{default: '0};
	exp_pc.delete();
	exp_rd.delete();
	exp_data.delete();
	pc = reset_pc;
	stop = 1'b0;
	steps = 0;
	while (!stop && steps < 1000) begin
		w = prog_mem[pc[imem_addr_w+1:2]];
		opc = w[6:0];
		rd = w[11:7];
		f3 = w[14:12];
		f7 = w[31:25];
		// x0 is never written, so regs[0] stays zero
		a = regs[w[19:15]];
		b = regs[w[24:20]];
		imm_i = {{(xlen-12){w[31]}}, w[31:20]};
		imm_u = {{(xlen-32){w[31]}}, w[31:12], 12'h000};
		imm_j = {{(xlen-21){w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		imm_b = {{(xlen-13){w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		// anything not matched below is a no-op
		wr = 1'b0;
		res = '0;
		next_pc = pc + xlen'(4);
		case (opc)
			op_reg: begin
				wr = 1'b1;
				case ({f7, f3})
					{f7_base, f3_add_sub}: res = a + b;
					{f7_sub, f3_add_sub}: res = a - b;
					{f7_base, f3_and}: res = a & b;
					{f7_base, f3_or}: res = a | b;
					{f7_base, f3_xor}: res = a ^ b;
					{f7_base, f3_sll}: res = a << b[5:0];
					{f7_base, f3_srl}: res = a >> b[5:0];
					default: wr = 1'b0;
				endcase
			end
			op_imm: begin
				wr = 1'b1;
				case (f3)
					f3_add_sub: res = a + imm_i;
					f3_and: res = a & imm_i;
					f3_or: res = a | imm_i;
					f3_xor: res = a ^ imm_i;
					// six-bit shamt, upper funct6 must be zero
					f3_sll: res = a << w[25:20];
					f3_srl: res = a >> w[25:20];
					default: wr = 1'b0;
				endcase
				if ((f3 == f3_sll || f3 == f3_srl) && w[31:26] != 6'd0) begin
					wr = 1'b0;
				end
			end
			op_lui: begin
				wr = 1'b1;
				res = imm_u;
			end
			op_auipc: begin
				wr = 1'b1;
				res = pc + imm_u;
			end
			op_jal: begin
				wr = 1'b1;
				res = pc + xlen'(4);
				next_pc = pc + imm_j;
			end
			op_branch: begin
				if ((f3 == f3_beq && a == b) || (f3 == f3_bne && a != b)) begin
					next_pc = pc + imm_b;
				end
			end
			op_system: stop = (w == inst_ebreak);
			default: ;
		endcase
		if (wr && rd != '0) begin
			regs[rd] = res;
			exp_rd.push_back(rd);
			exp_data.push_back(res);
		end else begin
			exp_rd.push_back('0);
			exp_data.push_back('0);
		end
		exp_pc.push_back(pc);
		pc = next_pc;
		steps++;
	end
endfunction

// *********************************************************************
// program encoders
// *********************************************************************
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, op_reg};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd);
	return {imm, rs1, f3, rd, op_imm};
endfunction

function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [19:0] imm,
		input logic [4:0] rd);
	return {imm, rd, opc};
endfunction

// offset is the byte distance, bit 0 dropped
function automatic logic [31:0] enc_jal(input logic [20:0] off, input logic [4:0] rd);
	return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
endfunction

function automatic logic [31:0] enc_br(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
endfunction

// galois lfsr, taps 32 31 29 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'hd0000001) : (s >> 1);
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] val;
	int i;
	val = '0;
	for (i = 0; i < n; i++) begin
		val = {val[30:0], lfsr_state[0]};
		lfsr_state = lfsr_next(lfsr_state);
	end
	return val;
endfunction

`endif

// ==== tests/tb_core.sv ====
// each of the five programs is loaded whole into imem under reset and retire beats are compared at negedge
`timescale 1ns/100ps

module tb_core
	import core_pkg::*;
();

	logic clk;
	logic rst;
	logic imem_we;
	logic [imem_addr_w-1:0] imem_addr;
	logic [inst_w-1:0] imem_wdata;
	logic [xlen-1:0] pc;
	logic retire_valid;
	logic [xlen-1:0] retire_pc;
	logic [reg_addr_w-1:0] retire_rd;
	logic [xlen-1:0] retire_data;
	logic halted;

	// per-test state shared with the compare process
	string test_name;
	bit checking;
	int exp_idx;
	int test_errors;
	int pass_count;
	int fail_count;
	// words shown on the pc output in fetch order
	logic [xlen-1:0] seen_pc [$];

	`include "tb_ref_model.svh"

	npc_core DUT (
		.clk, .rst, .imem_we, .imem_addr, .imem_wdata,
		.pc, .retire_valid, .retire_pc, .retire_rd, .retire_data, .halted
	);

	// 40 ns clock
	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// *****************************************************************
	// program builders
	// *****************************************************************

	// unknown custom-0 opcode that carries the whole address
	function automatic logic [31:0] fill_word(input int addr);
		return {8'h00, 8'(addr), ~8'(addr), 8'h0b};
	endfunction

	function automatic void clear_prog();
		int i;
		for (i = 0; i < imem_depth; i++) begin
			prog_mem[imem_addr_w'(i)] = fill_word(i);
		end
		prog_len = 0;
	endfunction

	function automatic void emit(input logic [31:0] w);
		prog_mem[imem_addr_w'(prog_len)] = w;
		prog_len++;
	endfunction

	function automatic void build_alu_prog();
		clear_prog();
		// x1 = 0x12345678, x2 = -5, x3 = sign-extended 0x80000000
		emit(enc_u(op_lui, 20'h12345, 5'd1));
		emit(enc_i(12'h678, 5'd1, f3_add_sub, 5'd1));
		emit(enc_i(12'hffb, 5'd0, f3_add_sub, 5'd2));
		emit(enc_u(op_lui, 20'h80000, 5'd3));
		emit(enc_r(f7_base, 5'd2, 5'd1, f3_add_sub, 5'd4));
		emit(enc_r(f7_sub, 5'd2, 5'd1, f3_add_sub, 5'd5));
		emit(enc_r(f7_base, 5'd2, 5'd1, f3_and, 5'd6));
		emit(enc_r(f7_base, 5'd3, 5'd1, f3_or, 5'd7));
		emit(enc_r(f7_base, 5'd2, 5'd1, f3_xor, 5'd8));
		// shift by 36 crosses the 32-bit boundary
		emit(enc_i(12'd36, 5'd0, f3_add_sub, 5'd9));
		emit(enc_r(f7_base, 5'd9, 5'd1, f3_sll, 5'd10));
		emit(enc_r(f7_base, 5'd9, 5'd3, f3_srl, 5'd11));
		emit(enc_i(12'h0f0, 5'd1, f3_and, 5'd12));
		emit(enc_i(12'h800, 5'd1, f3_or, 5'd13));
		emit(enc_i(12'h7ff, 5'd2, f3_xor, 5'd14));
		emit(enc_i(12'd40, 5'd1, f3_sll, 5'd15));
		emit(enc_i(12'd4, 5'd3, f3_srl, 5'd16));
		emit(enc_u(op_auipc, 20'h00001, 5'd17));
		emit(inst_ebreak);
	endfunction

	function automatic void build_hazard_prog();
		int i;
		clear_prog();
		emit(enc_i(12'd1, 5'd0, f3_add_sub, 5'd1));
		// x1 doubles five times and each add reads the last
		for (i = 0; i < 5; i++) begin
			emit(enc_r(f7_base, 5'd1, 5'd1, f3_add_sub, 5'd1));
		end
		emit(enc_i(12'd3, 5'd1, f3_add_sub, 5'd2));
		emit(enc_r(f7_sub, 5'd1, 5'd2, f3_add_sub, 5'd3));
		emit(enc_r(f7_base, 5'd2, 5'd3, f3_xor, 5'd4));
		emit(enc_r(f7_base, 5'd1, 5'd4, f3_sll, 5'd5));
		// rewrite of a source just read
		emit(enc_i(12'd1, 5'd1, f3_add_sub, 5'd1));
		emit(enc_r(f7_base, 5'd1, 5'd5, f3_or, 5'd6));
		emit(enc_i(12'd7, 5'd6, f3_add_sub, 5'd6));
		emit(enc_r(f7_base, 5'd6, 5'd6, f3_add_sub, 5'd7));
		emit(enc_i(12'hfff, 5'd7, f3_xor, 5'd7));
		emit(inst_ebreak);
	endfunction

	function automatic void build_control_prog();
		clear_prog();
		emit(enc_i(12'd5, 5'd0, f3_add_sub, 5'd1));
		emit(enc_i(12'd5, 5'd0, f3_add_sub, 5'd2));
		// beq taken over two words
		emit(enc_br(13'd12, 5'd2, 5'd1, f3_beq));
		emit(enc_i(12'd1, 5'd0, f3_add_sub, 5'd3));
		emit(enc_i(12'd2, 5'd0, f3_add_sub, 5'd3));
		// bne not taken
		emit(enc_br(13'd8, 5'd2, 5'd1, f3_bne));
		emit(enc_i(12'd3, 5'd0, f3_add_sub, 5'd4));
		// taken bne skips a wrong-path ebreak
		emit(enc_br(13'd12, 5'd4, 5'd1, f3_bne));
		emit(enc_i(12'd9, 5'd0, f3_add_sub, 5'd5));
		emit(inst_ebreak);
		// beq not taken
		emit(enc_br(13'd8, 5'd4, 5'd1, f3_beq));
		// jal with link in x6
		emit(enc_jal(21'd12, 5'd6));
		emit(enc_i(12'd1, 5'd0, f3_add_sub, 5'd7));
		emit(inst_ebreak);
		emit(enc_r(f7_base, 5'd1, 5'd6, f3_add_sub, 5'd8));
		// plain jump drops its link into x0
		emit(enc_jal(21'd8, 5'd0));
		emit(enc_i(12'd1, 5'd0, f3_add_sub, 5'd9));
		emit(inst_ebreak);
	endfunction

	function automatic void build_x0_prog();
		clear_prog();
		emit(enc_i(12'd5, 5'd0, f3_add_sub, 5'd0));
		emit(enc_u(op_lui, 20'habcde, 5'd0));
		emit(enc_r(f7_base, 5'd0, 5'd0, f3_add_sub, 5'd1));
		emit(enc_i(12'd7, 5'd0, f3_add_sub, 5'd2));
		emit(enc_r(f7_base, 5'd2, 5'd2, f3_add_sub, 5'd0));
		emit(enc_r(f7_base, 5'd2, 5'd0, f3_add_sub, 5'd3));
		// slti, srai, mul, ecall and a custom word must all leave x5 alone
		emit(enc_i(12'd1, 5'd0, 3'b010, 5'd5));
		emit(enc_i(12'h403, 5'd2, f3_srl, 5'd5));
		emit(enc_r(7'b0000001, 5'd2, 5'd2, f3_add_sub, 5'd5));
		emit(32'h00000073);
		emit(fill_word(prog_len));
		emit(enc_i(12'd1, 5'd5, f3_add_sub, 5'd6));
		emit(inst_ebreak);
	endfunction

	function automatic void build_random_prog();
		int i;
		logic [3:0] sel;
		logic [4:0] rd, rs1, rs2;
		logic [11:0] imm;
		clear_prog();
		for (i = 0; i < 200; i++) begin
			// x0..x15 keeps dependencies frequent
			sel = 4'(rand_bits(4));
			rd = 5'(rand_bits(4));
			rs1 = 5'(rand_bits(4));
			rs2 = 5'(rand_bits(4));
			imm = 12'(rand_bits(12));
			case (sel)
				4'd0: emit(enc_r(f7_base, rs2, rs1, f3_add_sub, rd));
				4'd1: emit(enc_r(f7_sub, rs2, rs1, f3_add_sub, rd));
				4'd2: emit(enc_r(f7_base, rs2, rs1, f3_and, rd));
				4'd3: emit(enc_r(f7_base, rs2, rs1, f3_or, rd));
				4'd4: emit(enc_r(f7_base, rs2, rs1, f3_xor, rd));
				4'd5: emit(enc_r(f7_base, rs2, rs1, f3_sll, rd));
				4'd6: emit(enc_r(f7_base, rs2, rs1, f3_srl, rd));
				4'd7: emit(enc_i(imm, rs1, f3_and, rd));
				4'd8: emit(enc_i(imm, rs1, f3_or, rd));
				4'd9: emit(enc_i(imm, rs1, f3_xor, rd));
				4'd10: emit(enc_i({6'd0, imm[5:0]}, rs1, f3_sll, rd));
				4'd11: emit(enc_i({6'd0, imm[5:0]}, rs1, f3_srl, rd));
				// addi takes the rest and supplies most nonzero values
				default: emit(enc_i(imm, rs1, f3_add_sub, rd));
			endcase
		end
		emit(inst_ebreak);
	endfunction

	// *****************************************************************
	// load, run and judge one program
	// *****************************************************************
	task automatic run_program(input string name);
		int i;
		int cyc;
		bit done;
		test_name = name;
		test_errors = 0;
		ref_run();
		@(posedge clk);
		rst <= 1'b1;
		imem_we <= 1'b0;
		// one reset edge first so fd_valid is already low
		@(posedge clk);
		for (i = 0; i < imem_depth; i++) begin
			imem_we <= 1'b1;
			imem_addr <= imem_addr_w'(i);
			imem_wdata <= prog_mem[imem_addr_w'(i)];
			@(posedge clk);
		end
		imem_we <= 1'b0;
		// two more reset cycles after the last write
		repeat (2) @(posedge clk);
		exp_idx = 0;
		seen_pc.delete();
		checking = 1'b1;
		rst <= 1'b0;
		done = 1'b0;
		for (cyc = 0; cyc < 2000 && !done; cyc++) begin
			@(negedge clk);
			if (halted === 1'b1) begin
				done = 1'b1;
			end
		end
		// let the compare process take the ebreak beat
		repeat (2) @(negedge clk);
		checking = 1'b0;
		if (!done) begin
			$display("test %s: halted did not rise within 2000 cycles", name);
			test_errors++;
		end else if (exp_idx != exp_pc.size()) begin
			$display("test %s: wrong retire count, expected %0d retirements but saw %0d",
				name, exp_pc.size(), exp_idx);
			test_errors++;
		end
		if (test_errors == 0) begin
			pass_count++;
			$display("PASS %s (%0d retirements)", name, exp_idx);
		end else begin
			fail_count++;
			$display("FAIL %s (%0d errors)", name, test_errors);
		end
	endtask

	// each retire beat against the next expected entry
	always @(negedge clk) begin
		if (checking && (seen_pc.size() == 0 || seen_pc[$] !== pc)) begin
			seen_pc.push_back(pc);
		end
		if (checking && retire_valid === 1'b1) begin
			if (exp_idx >= exp_pc.size()) begin
				$display("test %s: unexpected retirement at pc %h after the last expected one",
					test_name, retire_pc);
				test_errors++;
			end else begin
				if (retire_pc !== exp_pc[exp_idx]) begin
					$display("FAILED %s retire %0d pc: expected %h, actual %h",
						test_name, exp_idx, exp_pc[exp_idx], retire_pc);
					test_errors++;
				end
				if (retire_rd !== exp_rd[exp_idx]) begin
					$display("FAILED %s retire %0d rd: expected %0d, actual %0d",
						test_name, exp_idx, exp_rd[exp_idx], retire_rd);
					test_errors++;
				end
				if (retire_data !== exp_data[exp_idx]) begin
					$display("FAILED %s retire %0d data: expected %h, actual %h",
						test_name, exp_idx, exp_data[exp_idx], retire_data);
					test_errors++;
				end
				// every retired word sat in decode earlier, wrong-path words are skipped
				while (seen_pc.size() > 0 && seen_pc[0] !== exp_pc[exp_idx]) begin
					void'(seen_pc.pop_front());
				end
				if (seen_pc.size() == 0) begin
					$display("test %s: pc output never showed %h before retire %0d",
						test_name, exp_pc[exp_idx], exp_idx);
					test_errors++;
				end else begin
					void'(seen_pc.pop_front());
				end
			end
			exp_idx++;
		end
	end

	initial begin
		rst = 1'b1;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		checking = 1'b0;
		exp_idx = 0;
		test_errors = 0;
		pass_count = 0;
		fail_count = 0;
		repeat (2) @(posedge clk);
		build_alu_prog();
		run_program("alu_ops");
		build_hazard_prog();
		run_program("hazards");
		build_control_prog();
		run_program("control_flow");
		build_x0_prog();
		run_program("x0_and_noops");
		build_random_prog();
		run_program("random_alu");
		$display("%0d tests passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== design/npc_core.sv ====
// top of the rv64 subset core; load imem under reset, then watch retire and halted
`timescale 1ns/100ps

module npc_core import core_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	// program load
	input  logic                   imem_we,
	input  logic [imem_addr_w-1:0] imem_addr,
	input  logic [inst_w-1:0]      imem_wdata,
	// observation
	output logic [xlen-1:0]        pc,
	output logic                   retire_valid,
	output logic [xlen-1:0]        retire_pc,
	output logic [reg_addr_w-1:0]  retire_rd,
	output logic [xlen-1:0]        retire_data,
	output logic                   halted
);

	// fetch to decode
	logic fd_valid, fd_ready;
	logic [xlen-1:0] fd_pc;
	logic [inst_w-1:0] fd_inst;

	// decode to execute
	logic de_valid, de_ready;
	logic [xlen-1:0] de_pc, de_op_a, de_op_b, de_rs2_val, de_imm;
	alu_op_t de_alu_op;
	logic [reg_addr_w-1:0] de_rd;
	logic de_wen, de_is_branch, de_branch_ne, de_is_jal, de_is_halt;

	// register file and scoreboard
	logic [reg_addr_w-1:0] rs1_addr, rs2_addr, set_busy_rd, wb_rd;
	logic [xlen-1:0] rs1_val, rs2_val, wb_data;
	logic rs1_busy, rs2_busy, set_busy, wb_wen;

	// execute back to the front end
	logic redirect_valid;
	logic [xlen-1:0] redirect_pc;

	// pc seen from outside is the word sitting in decode
	assign pc = fd_pc;

	// ********************************************************************
	// pipeline
	// ********************************************************************
	fetch_stage u_fetch (
		.clk, .rst, .imem_we, .imem_addr, .imem_wdata,
		.redirect_valid, .redirect_pc, .halted,
		.fd_valid, .fd_ready, .fd_pc, .fd_inst
	);

	decode_stage u_decode (
		.clk, .rst, .fd_valid, .fd_ready, .fd_pc, .fd_inst, .redirect_valid,
		.rs1_addr, .rs2_addr, .rs1_val, .rs2_val, .rs1_busy, .rs2_busy,
		.set_busy, .set_busy_rd,
		.de_valid, .de_ready, .de_pc, .de_op_a, .de_op_b, .de_alu_op, .de_rs2_val,
		.de_imm, .de_rd, .de_wen, .de_is_branch, .de_branch_ne, .de_is_jal, .de_is_halt
	);

	reg_file_scoreboard u_regs (
		.clk, .rst, .rs1_addr, .rs2_addr, .rs1_val, .rs2_val, .rs1_busy, .rs2_busy,
		.wb_wen, .wb_rd, .wb_data, .set_busy, .set_busy_rd
	);

	execute_stage u_execute (
		.clk, .rst,
		.de_valid, .de_ready, .de_pc, .de_op_a, .de_op_b, .de_alu_op, .de_rs2_val,
		.de_imm, .de_rd, .de_wen, .de_is_branch, .de_branch_ne, .de_is_jal, .de_is_halt,
		.redirect_valid, .redirect_pc, .wb_wen, .wb_rd, .wb_data,
		.retire_valid, .retire_pc, .retire_rd, .retire_data, .halted
	);

endmodule

// ==== design/execute_stage.sv ====
// never stalls; redirect is combinational from the issued word; retire_rd/data are 0 unless rd written
`timescale 1ns/100ps

module execute_stage import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	// from decode
	input  logic                  de_valid,
	output logic                  de_ready,
	input  logic [xlen-1:0]       de_pc,
	input  logic [xlen-1:0]       de_op_a,
	input  logic [xlen-1:0]       de_op_b,
	input  alu_op_t               de_alu_op,
	input  logic [xlen-1:0]       de_rs2_val,
	input  logic [xlen-1:0]       de_imm,
	input  logic [reg_addr_w-1:0] de_rd,
	input  logic                  de_wen,
	input  logic                  de_is_branch,
	input  logic                  de_branch_ne,
	input  logic                  de_is_jal,
	input  logic                  de_is_halt,
	// to fetch and decode
	output logic                  redirect_valid,
	output logic [xlen-1:0]       redirect_pc,
	// to the register file
	output logic                  wb_wen,
	output logic [reg_addr_w-1:0] wb_rd,
	output logic [xlen-1:0]       wb_data,
	// retire port
	output logic                  retire_valid,
	output logic [xlen-1:0]       retire_pc,
	output logic [reg_addr_w-1:0] retire_rd,
	output logic [xlen-1:0]       retire_data,
	output logic                  halted
);

	logic [xlen-1:0] alu_result;
	logic take;
	logic br_eq, br_taken;

	// single-cycle alu, always ready
	assign de_ready = 1'b1;
	// once halted, anything still issued is dropped
	assign take = de_valid && !halted;

	always_comb begin
		case (de_alu_op)
			alu_add: alu_result = de_op_a + de_op_b;
			alu_sub: alu_result = de_op_a - de_op_b;
			alu_and: alu_result = de_op_a & de_op_b;
			alu_or: alu_result = de_op_a | de_op_b;
			alu_xor: alu_result = de_op_a ^ de_op_b;
			// rv64 shift amount is six bits
			alu_sll: alu_result = de_op_a << de_op_b[5:0];
			alu_srl: alu_result = de_op_a >> de_op_b[5:0];
			default: alu_result = de_op_b;
		endcase
	end

	// ********************************************************************
	// branch and jump resolution
	// ********************************************************************
	assign br_eq = (de_op_a == de_rs2_val);
	assign br_taken = de_is_branch && (de_branch_ne ? !br_eq : br_eq);
	// one cycle wide, decode goes empty behind it
	assign redirect_valid = take && (de_is_jal || br_taken);
	assign redirect_pc = de_pc + de_imm;

	// execute-to-write control
	always_ff @(posedge clk) begin
		if (rst) begin
			retire_valid <= 1'b0;
			halted <= 1'b0;
		end else begin
			retire_valid <= take;
			if (take && de_is_halt) begin
				halted <= 1'b1;
			end
		end
	end

	// retire payload
	always_ff @(posedge clk) begin
		if (take) begin
			retire_pc <= de_pc;
			retire_rd <= de_wen ? de_rd : '0;
			retire_data <= de_wen ? alu_result : '0;
		end
	end

	// write lands on the edge that ends the retire beat
	assign wb_wen = retire_valid && (retire_rd != '0);
	assign wb_rd = retire_rd;
	assign wb_data = retire_data;

	// the flush leaves decode empty, so no back-to-back redirect
	a_redirect_pulse: assert property (@(posedge clk) disable iff (rst)
		redirect_valid |=> !redirect_valid)
		else $error("redirect_valid high two cycles in a row");

endmodule

// ==== design/reg_file_scoreboard.sv ====
// reads are combinational with no write bypass; x0 reads zero and is never busy
`timescale 1ns/100ps

module reg_file_scoreboard import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	// read ports
	input  logic [reg_addr_w-1:0] rs1_addr,
	input  logic [reg_addr_w-1:0] rs2_addr,
	output logic [xlen-1:0]       rs1_val,
	output logic [xlen-1:0]       rs2_val,
	output logic                  rs1_busy,
	output logic                  rs2_busy,
	// write port from execute
	input  logic                  wb_wen,
	input  logic [reg_addr_w-1:0] wb_rd,
	input  logic [xlen-1:0]       wb_data,
	// issue marks rd pending
	input  logic                  set_busy,
	input  logic [reg_addr_w-1:0] set_busy_rd
);

	logic [xlen-1:0] regs [reg_count];
	logic [reg_count-1:0] busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			regs <= '{default: '0};
		end else if (wb_wen && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// scoreboard, set after clear so a same-edge set wins
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= '0;
		end else begin
			if (wb_wen) begin
				busy[wb_rd] <= 1'b0;
			end
			if (set_busy && set_busy_rd != '0) begin
				busy[set_busy_rd] <= 1'b1;
			end
		end
	end

	assign rs1_val = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_val = (rs2_addr == '0) ? '0 : regs[rs2_addr];
	assign rs1_busy = (rs1_addr != '0) && busy[rs1_addr];
	assign rs2_busy = (rs2_addr != '0) && busy[rs2_addr];

endmodule

// ==== design/decode_stage.sv ====
// stalls on busy sources and on a same-rd writer still in execute since there is no forwarding
`timescale 1ns/100ps

module decode_stage import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	// from fetch
	input  logic                  fd_valid,
	output logic                  fd_ready,
	input  logic [xlen-1:0]       fd_pc,
	input  logic [inst_w-1:0]     fd_inst,
	input  logic                  redirect_valid,
	// register file and scoreboard
	output logic [reg_addr_w-1:0] rs1_addr,
	output logic [reg_addr_w-1:0] rs2_addr,
	input  logic [xlen-1:0]       rs1_val,
	input  logic [xlen-1:0]       rs2_val,
	input  logic                  rs1_busy,
	input  logic                  rs2_busy,
	output logic                  set_busy,
	output logic [reg_addr_w-1:0] set_busy_rd,
	// to execute
	output logic                  de_valid,
	input  logic                  de_ready,
	output logic [xlen-1:0]       de_pc,
	output logic [xlen-1:0]       de_op_a,
	output logic [xlen-1:0]       de_op_b,
	output alu_op_t               de_alu_op,
	output logic [xlen-1:0]       de_rs2_val,
	output logic [xlen-1:0]       de_imm,
	output logic [reg_addr_w-1:0] de_rd,
	output logic                  de_wen,
	output logic                  de_is_branch,
	output logic                  de_branch_ne,
	output logic                  de_is_jal,
	output logic                  de_is_halt
);

	logic [6:0] opcode;
	logic [2:0] f3;
	logic [6:0] f7;
	logic [reg_addr_w-1:0] rd;
	logic [xlen-1:0] imm_i, imm_u, imm_j, imm_b;
	// decoded controls
	alu_op_t alu_op;
	logic [xlen-1:0] op_a, op_b, imm;
	logic writes, use_rs1, use_rs2;
	logic is_branch, branch_ne, is_jal, is_halt;
	logic wen;
	logic src_hazard, waw_hazard, issue;

	assign opcode = fd_inst[6:0];
	assign rd = fd_inst[11:7];
	assign f3 = fd_inst[14:12];
	assign rs1_addr = fd_inst[19:15];
	assign rs2_addr = fd_inst[24:20];
	assign f7 = fd_inst[31:25];

	// sign-extended immediates
	assign imm_i = {{(xlen-12){fd_inst[31]}}, fd_inst[31:20]};
	assign imm_u = {{(xlen-32){fd_inst[31]}}, fd_inst[31:12], 12'b0};
	assign imm_j = {{(xlen-21){fd_inst[31]}}, fd_inst[31], fd_inst[19:12], fd_inst[20],
		fd_inst[30:21], 1'b0};
	assign imm_b = {{(xlen-13){fd_inst[31]}}, fd_inst[31], fd_inst[7], fd_inst[30:25],
		fd_inst[11:8], 1'b0};

	// ********************************************************************
	// instruction decode
	// ********************************************************************
	always_comb begin
		// defaults describe a no-op
		alu_op = alu_add;
		op_a = rs1_val;
		op_b = rs2_val;
		imm = '0;
		writes = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		is_branch = 1'b0;
		branch_ne = 1'b0;
		is_jal = 1'b0;
		is_halt = 1'b0;
		case (opcode)
			op_reg: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				writes = 1'b1;
				case ({f7, f3})
					{f7_base, f3_add_sub}: alu_op = alu_add;
					{f7_sub, f3_add_sub}: alu_op = alu_sub;
					{f7_base, f3_and}: alu_op = alu_and;
					{f7_base, f3_or}: alu_op = alu_or;
					{f7_base, f3_xor}: alu_op = alu_xor;
					{f7_base, f3_sll}: alu_op = alu_sll;
					{f7_base, f3_srl}: alu_op = alu_srl;
					default: begin
						writes = 1'b0;
						use_rs1 = 1'b0;
						use_rs2 = 1'b0;
					end
				endcase
			end
			op_imm: begin
				use_rs1 = 1'b1;
				writes = 1'b1;
				op_b = imm_i;
				case (f3)
					f3_add_sub: alu_op = alu_add;
					f3_and: alu_op = alu_and;
					f3_or: alu_op = alu_or;
					f3_xor: alu_op = alu_xor;
					// rv64 shifts take shamt from [25:20] and need a zero funct6
					f3_sll: alu_op = alu_sll;
					f3_srl: alu_op = alu_srl;
					default: begin
						writes = 1'b0;
						use_rs1 = 1'b0;
					end
				endcase
				if ((f3 == f3_sll || f3 == f3_srl) && f7[6:1] != f7_base[6:1]) begin
					writes = 1'b0;
					use_rs1 = 1'b0;
				end
			end
			op_lui: begin
				writes = 1'b1;
				op_b = imm_u;
				alu_op = alu_pass_b;
			end
			op_auipc: begin
				writes = 1'b1;
				op_a = fd_pc;
				op_b = imm_u;
			end
			op_jal: begin
				// link = pc + 4 through the adder
				writes = 1'b1;
				is_jal = 1'b1;
				op_a = fd_pc;
				op_b = xlen'(4);
				imm = imm_j;
			end
			op_branch: begin
				if (f3 == f3_beq || f3 == f3_bne) begin
					use_rs1 = 1'b1;
					use_rs2 = 1'b1;
					is_branch = 1'b1;
					branch_ne = (f3 == f3_bne);
					imm = imm_b;
				end
			end
			op_system: begin
				is_halt = (fd_inst == inst_ebreak);
			end
			default: ;
		endcase
	end

	// x0 is never written or marked busy
	assign wen = writes && (rd != '0);

	// ********************************************************************
	// hazard stall and issue
	// ********************************************************************
	assign src_hazard = (use_rs1 && rs1_busy) || (use_rs2 && rs2_busy);
	// a same-rd writer still in execute would clear busy after our set
	assign waw_hazard = wen && de_valid && de_wen && (de_rd == rd);
	// redirect kills the wrong-path word before it can set busy
	assign fd_ready = (!de_valid || de_ready) && !src_hazard && !waw_hazard && !redirect_valid;
	assign issue = fd_valid && fd_ready;

	assign set_busy = issue && wen;
	assign set_busy_rd = rd;

	always_ff @(posedge clk) begin
		if (rst) begin
			de_valid <= 1'b0;
		end else if (issue) begin
			de_valid <= 1'b1;
		end else if (de_ready) begin
			de_valid <= 1'b0;
		end
	end

	// decode-to-execute payload
	always_ff @(posedge clk) begin
		if (issue) begin
			de_pc <= fd_pc;
			de_op_a <= op_a;
			de_op_b <= op_b;
			de_alu_op <= alu_op;
			de_rs2_val <= rs2_val;
			de_imm <= imm;
			de_rd <= rd;
			de_wen <= wen;
			de_is_branch <= is_branch;
			de_branch_ne <= branch_ne;
			de_is_jal <= is_jal;
			de_is_halt <= is_halt;
		end
	end

	// a writer sitting in execute keeps its rd busy, so no reader of it may issue
	a_issue_clean: assert property (@(posedge clk) disable iff (rst)
		issue && de_valid && de_wen |->
			!(use_rs1 && rs1_addr == de_rd) && !(use_rs2 && rs2_addr == de_rd))
		else $error("decode issued with a busy source");

endmodule

// ==== design/fetch_stage.sv ====
// imem loads only while the pipe is empty (under reset); pc wraps every 1 KiB of code
`timescale 1ns/100ps

module fetch_stage import core_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	// program load port
	input  logic                   imem_we,
	input  logic [imem_addr_w-1:0] imem_addr,
	input  logic [inst_w-1:0]      imem_wdata,
	// from execute
	input  logic                   redirect_valid,
	input  logic [xlen-1:0]        redirect_pc,
	input  logic                   halted,
	// to decode
	output logic                   fd_valid,
	input  logic                   fd_ready,
	output logic [xlen-1:0]        fd_pc,
	output logic [inst_w-1:0]      fd_inst
);

	logic [inst_w-1:0] imem [imem_depth];
	logic [xlen-1:0] pc_q;
	logic slot_free;
	logic fetch_go;

	// fd register empty or emptying this edge
	assign slot_free = !fd_valid || fd_ready;
	// a redirect beats a sequential fetch
	assign fetch_go = slot_free && !halted && !redirect_valid;

	// load port, written by the testbench
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_wdata;
		end
	end

	// ********************************************************************
	// pc and fetch-to-decode valid
	// ********************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= reset_pc;
			fd_valid <= 1'b0;
		end else if (redirect_valid) begin
			// flush the wrong-path word
			pc_q <= redirect_pc;
			fd_valid <= 1'b0;
		end else if (slot_free) begin
			// halted drains the register and freezes pc
			fd_valid <= !halted;
			if (!halted) begin
				pc_q <= pc_q + xlen'(4);
			end
		end
	end

	// payload, no reset
	always_ff @(posedge clk) begin
		if (fetch_go) begin
			fd_pc <= pc_q;
			fd_inst <= imem[pc_q[imem_addr_w+1:2]];
		end
	end

	// program must be in place before anything is in flight
	a_load_idle: assert property (@(posedge clk) imem_we |-> !fd_valid)
		else $error("imem written while fetch-to-decode holds an instruction");

endmodule

// ==== design/core_pkg.sv ====
// rv64 subset constants only; imem word-addressed from pc bits above [1:0], upper pc bits ignored
package core_pkg;

	// ********************************************************************
	// widths and sizes
	// ********************************************************************

	// data and pc width
	localparam int xlen = 64;
	// register index
	localparam int reg_addr_w = 5;
	localparam int reg_count = 2 ** reg_addr_w;
	// instruction word
	localparam int inst_w = 32;

	// instruction memory, 32-bit words
	localparam int imem_depth = 256;
	localparam int imem_addr_w = 8;

	// first fetch after reset
	localparam logic [xlen-1:0] reset_pc = '0;

	// ********************************************************************
	// encodings
	// ********************************************************************

	// major opcodes of the subset
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_system = 7'b1110011;

	// funct3 for alu ops, shared by reg and imm forms
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll = 3'b001;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_srl = 3'b101;
	localparam logic [2:0] f3_or = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;

	// funct3 for branches
	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;

	// funct7, sub only differs in bit 30
	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_sub = 7'b0100000;

	// the one system encoding we honour
	localparam logic [inst_w-1:0] inst_ebreak = 32'h00100073;

	// alu operations, pass_b feeds lui
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_pass_b
	} alu_op_t;

endpackage
